/* project.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/control.sv
hdl/instr_fetch.sv
hdl/credit_fifo.sv
hdl/instr_decode.sv
hdl/mips_decode_top.sv
sim/decode_checker.sv
sim/tb_mips_decode.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f project.f --top-module tb_mips_decode -o tb_mips_decode

out=$(./obj_dir/tb_mips_decode)
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1

/* sim/tb_mips_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mips_config.svh"

module tb_mips_decode
    import mips_pkg::*;
    ();

    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   rst;
    logic                   load_we;
    pc_t                    load_addr;
    instr_t                 load_data;
    logic                   start;
    logic [`MIPS_NB_PC:0]   instr_count;
    logic                   hold;
    logic                   done;
    logic                   valid;
    pc_t                    pc;
    ctrl_wb_t               wb_bus;
    ctrl_mem_t              mem_bus;
    ctrl_exc_t              exc_bus;
    reg_idx_t               rs;
    reg_idx_t               rt;
    reg_idx_t               rd_dst;
    instr_t                 imm_ext;
    int                     accepted;
    int                     chk_errors;
    logic [31:0]            lfsr_state;
    int                     local_errs = 0;
    int                     errs_before = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    logic                   aborted = 1'b0;

    mips_decode_top uut
    (
        .i_clk(clk), .i_rst(rst), .i_load_we(load_we), .i_load_addr(load_addr),
        .i_load_data(load_data), .i_start(start), .i_instr_count(instr_count),
        .i_hold(hold), .o_done(done), .o_valid(valid), .o_pc(pc),
        .o_ctrl_wb_bus(wb_bus), .o_ctrl_mem_bus(mem_bus), .o_ctrl_exc_bus(exc_bus),
        .o_rs(rs), .o_rt(rt), .o_rd_dst(rd_dst), .o_imm_ext(imm_ext)
    );

    decode_checker u_checker
    (
        .i_clk(clk), .i_rst(rst), .i_load_we(load_we), .i_load_addr(load_addr),
        .i_load_data(load_data), .i_start(start), .i_hold(hold), .i_valid(valid),
        .i_pc(pc), .i_ctrl_wb_bus(wb_bus), .i_ctrl_mem_bus(mem_bus),
        .i_ctrl_exc_bus(exc_bus), .i_rs(rs), .i_rt(rt), .i_rd_dst(rd_dst),
        .i_imm_ext(imm_ext), .o_accepted(accepted), .o_errors(chk_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic reset_dut();
        rst = 1'b0;
        start = 1'b0;
        hold = 1'b0;
        load_we = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b1;
    endtask

    task automatic load_program(input int n, input logic cycle_kinds);
        logic [31:0] r;
        logic [31:0] low;
        int          kind;
        opcode_t     op;
        for (int a = 0; a < n; a++)
        begin
            take_bits(3, r);
            kind = cycle_kinds ? a % 5 : r % 5;
            take_bits(6, r);
            case (kind)
                0:       op = 6'b000000;
                1:       op = 6'b100011;
                2:       op = 6'b101011;
                3:       op = 6'b000100;
                default: op = (r[5:0] inside {6'b000000, 6'b100011, 6'b101011, 6'b000100})
                              ? 6'b111111 : r[5:0];     // Some unsupported opcode
            endcase
            take_bits(26, low);
            @(negedge clk);
            load_we = 1'b1;
            load_addr = pc_t'(a);
            load_data = {op, low[25:0]};
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic run_program(input int n, input logic random_hold);
        logic [31:0] r;
        int          cycles;
        @(negedge clk);
        instr_count = 7'(n);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (done)
        begin
            $display("Mismatch at %0t: o_done still high after a new start", $time);
            local_errs++;
        end
        cycles = 0;
        while (!(done && accepted == n) && cycles < MAX_CYCLES)
        begin
            take_bits(1, r);
            hold = random_hold & r[0];
            @(negedge clk);
            cycles++;
        end
        hold = 1'b0;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: %0d of %0d results arrived, o_done=%0b", accepted, n, done);
            local_errs++;
            aborted = 1'b1;
        end
        else
        begin
            repeat (8) @(negedge clk);              // Drain window
            if (accepted != n || valid || !done)
            begin
                $display("Mismatch at %0t: run of %0d gave %0d results, o_valid=%0b o_done=%0b",
                         $time, n, accepted, valid, done);
                local_errs++;
            end
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        errs = chk_errors + local_errs - errs_before;
        errs_before = chk_errors + local_errs;
        if (errs == 0)
        begin
            tests_passed++;
            $display("Test %0d %s: ok", num, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    initial
    begin
        lfsr_state = 32'hdb41;
        load_addr = '0;
        load_data = '0;
        instr_count = '0;
        reset_dut();

        load_program(20, 1'b1);
        run_program(20, 1'b0);
        finish_test(1, "decode of all opcodes");

        if (!aborted)
        begin
            load_program(40, 1'b0);
            run_program(40, 1'b1);
            finish_test(2, "back-pressure");
        end
        if (!aborted)
        begin
            load_program(25, 1'b0);
            run_program(25, 1'b1);
            finish_test(3, "completion");
        end
        if (!aborted)
        begin
            load_program(40, 1'b0);
            @(negedge clk);
            instr_count = 7'd5;                     // Fits in queue and slot under hold
            start = 1'b1;
            hold = 1'b1;
            @(negedge clk);
            start = 1'b0;
            repeat (12) @(negedge clk);             // Fetch finishes, results stay held
            if (!(valid && done))
            begin
                $display("Mismatch at %0t: before reset o_valid=%0b o_done=%0b, expected 1 1",
                         $time, valid, done);
                local_errs++;
            end
            reset_dut();
            if (valid || done)
            begin
                $display("Mismatch at %0t: reset left o_valid=%0b o_done=%0b",
                         $time, valid, done);
                local_errs++;
            end
            run_program(40, 1'b1);
            finish_test(4, "reset mid-run");
        end
        if (!aborted)
        begin
            load_program(17, 1'b0);
            run_program(17, 1'b1);
            finish_test(5, "back-to-back runs");
        end

        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0 && chk_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/decode_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mips_config.svh"

module decode_checker
    import mips_pkg::*;
    (
        input  wire logic       i_clk,
        input  wire logic       i_rst,
        input  wire logic       i_load_we,
        input  wire pc_t        i_load_addr,
        input  wire instr_t     i_load_data,
        input  wire logic       i_start,
        input  wire logic       i_hold,
        input  wire logic       i_valid,
        input  wire pc_t        i_pc,
        input  wire ctrl_wb_t   i_ctrl_wb_bus,
        input  wire ctrl_mem_t  i_ctrl_mem_bus,
        input  wire ctrl_exc_t  i_ctrl_exc_bus,
        input  wire reg_idx_t   i_rs,
        input  wire reg_idx_t   i_rt,
        input  wire reg_idx_t   i_rd_dst,
        input  wire instr_t     i_imm_ext,
        output      int         o_accepted,         // Results taken in the current run
        output      int         o_errors
    );

    typedef logic [60:0] result_t;                  // pc, wb, mem, exc, rs, rt, dst, imm

    instr_t     model_mem [`MIPS_IMEM_DEPTH];       // Shadow of the loaded program
    pc_t        exp_pc;
    logic       held_q;
    result_t    held_val;
    result_t    got;
    int         err_count = 0;

    assign got = {i_pc, i_ctrl_wb_bus, i_ctrl_mem_bus, i_ctrl_exc_bus,
                  i_rs, i_rt, i_rd_dst, i_imm_ext};
    assign o_errors = err_count;

    // Decode table and field rules of the front end
    function automatic result_t expected_result(input pc_t pc, input instr_t instr);
        logic [7:0] buses;
        reg_idx_t   dst;
        case (instr[31:26])
            6'b000000: buses = 8'b10_000_100;       // R-type
            6'b100011: buses = 8'b11_010_001;       // LW
            6'b101011: buses = 8'b00_001_001;       // SW
            6'b000100: buses = 8'b00_100_000;       // BEQ
            default:   buses = 8'b00_000_000;
        endcase
        dst = buses[2] ? instr[15:11] : instr[20:16];
        return {pc, buses, instr[25:21], instr[20:16], dst, {{16{instr[15]}}, instr[15:0]}};
    endfunction

    always @(posedge i_clk)
    begin : compare
        result_t exp;
        exp = expected_result(exp_pc, model_mem[exp_pc]);
        if (i_load_we)
            model_mem[i_load_addr] <= i_load_data;
        if (!i_rst || i_start)
        begin
            exp_pc     <= '0;
            o_accepted <= 0;
            held_q     <= 1'b0;
        end
        else
        begin
            if (held_q && (!i_valid || got !== held_val))
            begin
                $display("Mismatch at %0t: held result changed from %h to %h",
                         $time, held_val, got);
                err_count = err_count + 1;
            end
            if (i_valid && !i_hold)
            begin
                if (got !== exp)
                begin
                    $display("Mismatch at %0t: pc %0d expected %h got %h",
                             $time, exp_pc, exp, got);
                    err_count = err_count + 1;
                end
                exp_pc     <= exp_pc + 1'b1;        // Results must come in PC order
                o_accepted <= o_accepted + 1;
            end
            held_q   <= i_valid && i_hold;
            held_val <= got;
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mips_config.svh"

module mips_decode_top
    import mips_pkg::*;
    (
        input  wire logic               i_clk,
        input  wire logic               i_rst,
        input  wire logic               i_load_we,
        input  wire pc_t                i_load_addr,
        input  wire instr_t             i_load_data,
        input  wire logic               i_start,
        input  wire logic [`MIPS_NB_PC:0] i_instr_count,
        input  wire logic               i_hold,
        output      logic               o_done,
        output      logic               o_valid,
        output      pc_t                o_pc,
        output      ctrl_wb_t           o_ctrl_wb_bus,
        output      ctrl_mem_t          o_ctrl_mem_bus,
        output      ctrl_exc_t          o_ctrl_exc_bus,
        output      reg_idx_t           o_rs,
        output      reg_idx_t           o_rt,
        output      reg_idx_t           o_rd_dst,
        output      instr_t             o_imm_ext
    );

    logic           push;
    fetch_entry_t   push_data;
    logic           credit;
    logic           q_valid;
    fetch_entry_t   q_head;
    logic           pop;

    instr_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_load_we      (i_load_we),
        .i_load_addr    (i_load_addr),
        .i_load_data    (i_load_data),
        .i_start        (i_start),
        .i_instr_count  (i_instr_count),
        .i_credit       (credit),
        .o_push         (push),
        .o_push_data    (push_data),
        .o_done         (o_done)
    );

    credit_fifo #(.T(fetch_entry_t), .DEPTH(`MIPS_QUEUE_DEPTH)) u_queue
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_push         (push),
        .i_push_data    (push_data),
        .i_pop          (pop),
        .o_valid        (q_valid),
        .o_head         (q_head),
        .o_credit       (credit)
    );

    instr_decode u_decode
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (q_valid),
        .i_entry        (q_head),
        .i_hold         (i_hold),
        .o_pop          (pop),
        .o_valid        (o_valid),
        .o_pc           (o_pc),
        .o_ctrl_wb_bus  (o_ctrl_wb_bus),
        .o_ctrl_mem_bus (o_ctrl_mem_bus),
        .o_ctrl_exc_bus (o_ctrl_exc_bus),
        .o_rs           (o_rs),
        .o_rt           (o_rt),
        .o_rd_dst       (o_rd_dst),
        .o_imm_ext      (o_imm_ext)
    );

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decode
    import mips_pkg::*;
    (
        input  wire logic           i_clk,
        input  wire logic           i_rst,
        // Queue head
        input  wire logic           i_valid,
        input  wire fetch_entry_t   i_entry,
        // Output stall
        input  wire logic           i_hold,
        output      logic           o_pop,
        output      logic           o_valid,
        output      pc_t            o_pc,
        output      ctrl_wb_t       o_ctrl_wb_bus,
        output      ctrl_mem_t      o_ctrl_mem_bus,
        output      ctrl_exc_t      o_ctrl_exc_bus,
        output      reg_idx_t       o_rs,
        output      reg_idx_t       o_rt,
        output      reg_idx_t       o_rd_dst,
        output      instr_t         o_imm_ext
    );

    localparam int NB_IMM = 16;

    opcode_t            opcode;
    reg_idx_t           rs;
    reg_idx_t           rt;
    reg_idx_t           rd;
    logic [NB_IMM-1:0]  imm;
    ctrl_wb_t           dec_wb;
    ctrl_mem_t          dec_mem;
    ctrl_exc_t          dec_exc;
    logic               take;

    assign opcode = i_entry.instr[31:26];
    assign rs     = i_entry.instr[25:21];
    assign rt     = i_entry.instr[20:16];
    assign rd     = i_entry.instr[15:11];
    assign imm    = i_entry.instr[NB_IMM-1:0];

    control u_control
    (
        .i_opcode       (opcode),
        .o_ctrl_wb_bus  (dec_wb),
        .o_ctrl_mem_bus (dec_mem),
        .o_ctrl_exc_bus (dec_exc)
    );

    // Slot empty or being drained this cycle
    assign take  = i_valid && (!o_valid || !i_hold);
    assign o_pop = take;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
            o_valid <= 1'b0;
        else if (take)
            o_valid <= 1'b1;
        else if (!i_hold)
            o_valid <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (take)
        begin
            o_pc           <= i_entry.pc;
            o_ctrl_wb_bus  <= dec_wb;
            o_ctrl_mem_bus <= dec_mem;
            o_ctrl_exc_bus <= dec_exc;
            o_rs           <= rs;
            o_rt           <= rt;
            o_rd_dst       <= dec_exc[2] ? rd : rt;     // RegDst picks rd
            o_imm_ext      <= {{(32 - NB_IMM){imm[NB_IMM-1]}}, imm};
        end
    end

    // A held result must not move until it is consumed
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (o_valid && i_hold) |=> (o_valid && $stable(o_pc) && $stable(o_ctrl_wb_bus)
            && $stable(o_ctrl_mem_bus) && $stable(o_ctrl_exc_bus) && $stable(o_rs)
            && $stable(o_rt) && $stable(o_rd_dst) && $stable(o_imm_ext)))
        else $error("instr_decode: held output changed");

endmodule

`default_nettype wire

/* hdl/credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mips_config.svh"

module credit_fifo
    import mips_pkg::*;
    #(
        parameter type T     = fetch_entry_t,
        parameter int  DEPTH = `MIPS_QUEUE_DEPTH
    )
    (
        input  wire logic   i_clk,
        input  wire logic   i_rst,
        input  wire logic   i_push,
        input  wire T       i_push_data,
        input  wire logic   i_pop,
        output      logic   o_valid,
        output      T       o_head,
        output      logic   o_credit        // One pulse per pop, a cycle later
    );

    localparam int NB_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int NB_CNT = $clog2(DEPTH + 1);

    T                   mem [DEPTH];
    logic [NB_PTR-1:0]  wr_ptr;
    logic [NB_PTR-1:0]  rd_ptr;
    logic [NB_CNT-1:0]  count;

    assign o_valid = (count != '0);
    assign o_head  = mem[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            mem[wr_ptr] <= i_push_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            o_credit <= i_pop;

            if (i_push)
                wr_ptr <= (wr_ptr == NB_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (i_pop)
                rd_ptr <= (rd_ptr == NB_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // Sender must hold back when out of credit
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (count == NB_CNT'(DEPTH)) |-> !i_push)
        else $error("credit_fifo: push into a full queue");

    assert property (@(posedge i_clk) disable iff (!i_rst)
        i_pop |-> o_valid)
        else $error("credit_fifo: pop from an empty queue");

endmodule

`default_nettype wire

/* hdl/instr_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mips_config.svh"

module instr_fetch
    import mips_pkg::*;
    (
        input  wire logic               i_clk,
        input  wire logic               i_rst,
        // Instruction memory load port
        input  wire logic               i_load_we,
        input  wire pc_t                i_load_addr,
        input  wire instr_t             i_load_data,
        // Run control
        input  wire logic               i_start,
        input  wire logic [`MIPS_NB_PC:0] i_instr_count,
        // Credit return from the queue
        input  wire logic               i_credit,
        output      logic               o_push,
        output      fetch_entry_t       o_push_data,
        output      logic               o_done
    );

    localparam int NB_CREDIT = $clog2(`MIPS_QUEUE_DEPTH + 1);

    instr_t                  imem [`MIPS_IMEM_DEPTH];
    logic                    running;
    pc_t                     pc;
    logic [`MIPS_NB_PC:0]    sent;           // Instructions pushed so far
    logic [`MIPS_NB_PC:0]    sent_next;
    logic [`MIPS_NB_PC:0]    count_q;        // Run length latched at start
    logic [NB_CREDIT-1:0]    credits;
    logic                    issue;

    assign sent_next = sent + 1'b1;
    assign issue     = running && (credits != '0) && (sent < count_q);

    // Memory is writable only between runs
    always_ff @(posedge i_clk)
    begin
        if (i_load_we && !running)
            imem[i_load_addr] <= i_load_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            running <= 1'b0;
            pc      <= '0;
            sent    <= '0;
            count_q <= '0;
            o_push  <= 1'b0;
            o_done  <= 1'b0;
        end
        else if (i_start)
        begin
            running <= (i_instr_count != '0);
            pc      <= '0;
            sent    <= '0;
            count_q <= i_instr_count;
            o_push  <= 1'b0;
            o_done  <= (i_instr_count == '0);    // Empty run finishes at once
        end
        else
        begin
            o_push <= issue;
            if (issue)
            begin
                pc   <= pc + 1'b1;
                sent <= sent_next;
                if (sent_next == count_q)
                begin
                    running <= 1'b0;
                    o_done  <= 1'b1;             // Last push leaves this cycle
                end
            end
        end
    end

    // Entry registered with the push strobe
    always_ff @(posedge i_clk)
    begin
        if (issue)
        begin
            o_push_data.pc    <= pc;
            o_push_data.instr <= imem[pc];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst)
            credits <= NB_CREDIT'(`MIPS_QUEUE_DEPTH);
        else
            credits <= credits - NB_CREDIT'(issue) + NB_CREDIT'(i_credit);
    end

    // A returned credit always matches an earlier push
    assert property (@(posedge i_clk) disable iff (!i_rst)
        credits <= NB_CREDIT'(`MIPS_QUEUE_DEPTH))
        else $error("instr_fetch: credit counter above queue depth");

endmodule

`default_nettype wire

/* hdl/control.sv */
`timescale 1ns/10ps
`default_nettype none

module control
    import mips_pkg::*;
    (
        input  wire opcode_t    i_opcode,
        output      ctrl_wb_t   o_ctrl_wb_bus,      // [ RegWrite, MemtoReg ]
        output      ctrl_mem_t  o_ctrl_mem_bus,     // [ Branch, MemRead, MemWrite ]
        output      ctrl_exc_t  o_ctrl_exc_bus      // [ RegDst, ALUSrc/ALUOp ]
    );

    always_comb
    begin
        case (i_opcode)
            6'b000000:                              // R-type
            begin
                o_ctrl_wb_bus  = 2'b10;
                o_ctrl_mem_bus = 3'b000;
                o_ctrl_exc_bus = 3'b100;
            end

            6'b100011:                              // LW
            begin
                o_ctrl_wb_bus  = 2'b11;
                o_ctrl_mem_bus = 3'b010;
                o_ctrl_exc_bus = 3'b001;
            end

            6'b101011:                              // SW
            begin
                o_ctrl_wb_bus  = 2'b00;
                o_ctrl_mem_bus = 3'b001;
                o_ctrl_exc_bus = 3'b001;
            end

            6'b000100:                              // BEQ
            begin
                o_ctrl_wb_bus  = 2'b00;
                o_ctrl_mem_bus = 3'b100;
                o_ctrl_exc_bus = 3'b000;
            end

            // Unsupported opcodes behave as a no-op
            default:
            begin
                o_ctrl_wb_bus  = 2'b00;
                o_ctrl_mem_bus = 3'b000;
                o_ctrl_exc_bus = 3'b000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mips_pkg.sv */
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    // Basic datapath types
    typedef logic [`MIPS_NB_INSTR-1:0]   instr_t;
    typedef logic [`MIPS_NB_PC-1:0]      pc_t;
    typedef logic [`MIPS_NB_OPCODE-1:0]  opcode_t;
    typedef logic [`MIPS_NB_REG-1:0]     reg_idx_t;

    // [ RegWrite, MemtoReg ]
    typedef logic [`MIPS_NB_CTRL_WB-1:0] ctrl_wb_t;

    // [ Branch, MemRead, MemWrite ]
    typedef logic [`MIPS_NB_CTRL_M-1:0]  ctrl_mem_t;

    // [ RegDst, ALUSrc/ALUOp code ]
    typedef logic [`MIPS_NB_CTRL_EX-1:0] ctrl_exc_t;

    // Queue payload, PC in the upper bits
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* hdl/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Instruction word and field widths
`define MIPS_NB_INSTR       32
`define MIPS_NB_PC          6      // Word address into the instruction memory
`define MIPS_NB_OPCODE      6
`define MIPS_NB_REG         5

// Control bus widths
`define MIPS_NB_CTRL_WB     2
`define MIPS_NB_CTRL_M      3
`define MIPS_NB_CTRL_EX     3

// Storage sizes
`define MIPS_QUEUE_DEPTH    4      // Also the initial credit count in fetch
`define MIPS_IMEM_DEPTH     64

`endif
